// ==== vlog.f ====
+incdir+source
source/dma_pkg.sv
source/dma_if.sv
source/reg_decode.sv
source/read_addr_gen.sv
source/byte_align.sv
source/obi_read_dma_top.sv
testbench/tb_clk_gen.sv
testbench/dma_chk.sv
testbench/tb_top.sv

// ==== Bender.yml ====
package:
  name: obi_read_dma

sources:
  - include_dirs:
      - source
    files:
      - source/dma_pkg.sv
      - source/dma_if.sv
      - source/reg_decode.sv
      - source/read_addr_gen.sv
      - source/byte_align.sv
      - source/obi_read_dma_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_clk_gen.sv
      - testbench/dma_chk.sv
      - testbench/tb_top.sv

// ==== testbench/tb_top.sv ====
////////////////////////////////////////////////////////////
// read DMA testbench
// register host, memory model with random delays, watchdog
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module tb_top;

	localparam int clk_period = 8;
	localparam int n_xfer     = 8;

	// source and length per transfer, the last one for the busy test
	int unsigned xfer_src [n_xfer] = '{'h40, 'h41, 'h52, 'h63, 'h71, 'h13, 'h22, 'h90};
	int unsigned xfer_len [n_xfer] = '{12, 5, 6, 7, 9, 3, 2, 16};

	logic                   clk;
	logic                   rst_n;
	logic                   sbr_req;
	logic                   sbr_gnt;
	logic [`DMA_DATA_W-1:0] sbr_addr;
	logic                   sbr_we;
	logic [`DMA_DATA_W-1:0] sbr_wdata;
	logic [`DMA_ID_W-1:0]   sbr_aid;
	logic                   sbr_rvalid;
	logic [`DMA_DATA_W-1:0] sbr_rdata;
	logic [`DMA_ID_W-1:0]   sbr_rid;
	logic                   mgr_req;
	logic                   mgr_gnt;
	logic [`DMA_DATA_W-1:0] mgr_addr;
	logic                   mgr_rvalid;
	logic [`DMA_DATA_W-1:0] mgr_rdata;

	logic [7:0]             mem [256];      // source bytes
	logic [`DMA_DATA_W-1:0] exp_cap [3];    // [0] newest word
	logic [`DMA_ID_W-1:0]   next_id;
	int                     err_cnt;
	logic [`DMA_DATA_W-1:0] rsp_addr_q [$]; // granted reads
	int                     rsp_due_q [$];  // cycle of each response

	tb_clk_gen #(.period_ns(clk_period), .rst_cycles(16)) u_clk_gen (
		.clk_o  (clk),
		.rst_no (rst_n)
	);

	obi_read_dma_top u_dut (
		.clk_i        (clk),
		.rst_ni       (rst_n),
		.sbr_req_i    (sbr_req),
		.sbr_gnt_o    (sbr_gnt),
		.sbr_addr_i   (sbr_addr),
		.sbr_we_i     (sbr_we),
		.sbr_wdata_i  (sbr_wdata),
		.sbr_aid_i    (sbr_aid),
		.sbr_rvalid_o (sbr_rvalid),
		.sbr_rdata_o  (sbr_rdata),
		.sbr_rid_o    (sbr_rid),
		.mgr_req_o    (mgr_req),
		.mgr_gnt_i    (mgr_gnt),
		.mgr_addr_o   (mgr_addr),
		.mgr_rvalid_i (mgr_rvalid),
		.mgr_rdata_i  (mgr_rdata)
	);

	bind obi_read_dma_top dma_chk u_chk (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.sbr_req_i    (sbr_req_i),
		.sbr_gnt_o    (sbr_gnt_o),
		.sbr_addr_i   (sbr_addr_i),
		.sbr_we_i     (sbr_we_i),
		.sbr_aid_i    (sbr_aid_i),
		.sbr_rvalid_o (sbr_rvalid_o),
		.sbr_rdata_o  (sbr_rdata_o),
		.sbr_rid_o    (sbr_rid_o),
		.mgr_req_o    (mgr_req_o),
		.mgr_gnt_i    (mgr_gnt_i),
		.mgr_addr_o   (mgr_addr_o),
		.mgr_rvalid_i (mgr_rvalid_i)
	);

	function automatic int reads_for(int unsigned src, int unsigned len);
		return (src % 4 + len + 3) / 4; // words touched
	endfunction

	function automatic logic [31:0] word_at(logic [31:0] addr);
		logic [7:0] a;
		a = addr[7:0];
		return {mem[8'(a + 3)], mem[8'(a + 2)], mem[8'(a + 1)], mem[a]}; // little endian
	endfunction

	task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("MISMATCH @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// register host, called 1 ns after an edge

	task automatic bus_access(bit we, logic [9:0] idx, logic [31:0] wdata,
		output logic [31:0] rdata);
		logic [`DMA_ID_W-1:0] id;
		id        = next_id;
		next_id   = next_id + 1'b1;
		sbr_req   = 1'b1;
		sbr_we    = we;
		sbr_addr  = {20'd0, idx, 2'b00};
		sbr_wdata = wdata;
		sbr_aid   = id;
		@(posedge clk);
		#1;
		sbr_req = 1'b0;
		sbr_we  = 1'b0;
		check_word("rvalid", 32'(sbr_rvalid), 32'd1); // one cycle after grant
		check_word("rid", 32'(sbr_rid), 32'(id));
		rdata = sbr_rdata;
	endtask

	task automatic read_reg(logic [9:0] idx, output logic [31:0] data);
		bus_access(1'b0, idx, '0, data);
	endtask

	task automatic write_reg(logic [9:0] idx, logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b1, idx, data, unused);
	endtask

	task automatic expect_reg(string what, logic [9:0] idx, logic [31:0] exp);
		logic [31:0] got;
		read_reg(idx, got);
		check_word(what, got, exp);
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		st = 32'd1;
		while (st[0])
			read_reg(`DMA_REG_STATUS, st); // watchdog bounds this
	endtask

	// packed stream from the source bytes, tail zeroed, shifted into the model
	task automatic model_xfer(int unsigned src, int unsigned len);
		logic [31:0] w;
		for (int k = 0; k < (len + 3) / 4; k++) begin
			w = '0;
			for (int j = 0; j < 4; j++)
				if (4 * k + j < len)
					w[8*j +: 8] = mem[8'(src + 4 * k + j)];
			exp_cap[2] = exp_cap[1];
			exp_cap[1] = exp_cap[0];
			exp_cap[0] = w;
		end
	endtask

	task automatic check_caps();
		expect_reg("DATA0", `DMA_REG_DATA0, exp_cap[0]);
		expect_reg("DATA1", `DMA_REG_DATA1, exp_cap[1]);
		expect_reg("DATA2", `DMA_REG_DATA2, exp_cap[2]);
	endtask

	task automatic run_xfer(int unsigned src, int unsigned len);
		write_reg(`DMA_REG_LEN, len);
		write_reg(`DMA_REG_CMD, src);
		expect_reg("busy during transfer", `DMA_REG_STATUS, 32'd1);
		wait_idle();
		model_xfer(src, len);
		check_caps();
	endtask

	////////////////////////////////////////////////////////////
	// memory model, grant after 0 to 2 cycles, in-order responses

	initial begin
		int          cyc;
		int          due;
		int          gnt_wait;
		bit          armed;
		logic        req_q;
		logic [31:0] addr_q;
		cyc        = 0;
		due        = 0;
		gnt_wait   = 0;
		armed      = 1'b0;
		req_q      = 1'b0;
		addr_q     = '0;
		mgr_gnt    = 1'b0;
		mgr_rvalid = 1'b0;
		mgr_rdata  = '0;
		forever begin
			@(posedge clk);
			#1;
			cyc++;
			if (mgr_gnt && req_q) begin // granted at the last edge
				due = cyc - 1 + $urandom_range(1, 3);
				if (rsp_due_q.size() > 0 && due <= rsp_due_q[$])
					due = rsp_due_q[$] + 1; // keep order
				rsp_addr_q.push_back(addr_q);
				rsp_due_q.push_back(due);
				armed = 1'b0;
			end
			mgr_rvalid = 1'b0;
			if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
				mgr_rvalid = 1'b1;
				mgr_rdata  = word_at(rsp_addr_q.pop_front());
				void'(rsp_due_q.pop_front());
			end
			mgr_gnt = 1'b0;
			if (mgr_req) begin
				if (!armed) begin
					gnt_wait = $urandom_range(0, 2);
					armed    = 1'b1;
				end
				if (gnt_wait == 0)
					mgr_gnt = 1'b1;
				else
					gnt_wait--;
			end
			req_q  = mgr_req;
			addr_q = mgr_addr;
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus and final status

	initial begin
		sbr_req   = 1'b0;
		sbr_we    = 1'b0;
		sbr_addr  = '0;
		sbr_wdata = '0;
		sbr_aid   = '0;
		next_id   = '0;
		err_cnt   = 0;
		exp_cap   = '{default: '0};
		void'($urandom(59298));
		foreach (mem[i])
			mem[i] = 8'($urandom);
		wait (rst_n === 1'b1);
		@(posedge clk);
		#1;
		// id word and unmapped reads
		expect_reg("MAGIC", `DMA_REG_MAGIC, `DMA_MAGIC);
		expect_reg("unmapped 7", 10'd7, `DMA_BAD_RDATA);
		expect_reg("unmapped 200", 10'd200, `DMA_BAD_RDATA);
		expect_reg("busy after reset", `DMA_REG_STATUS, 32'd0);
		// length reset and readback
		expect_reg("LEN reset", `DMA_REG_LEN, `DMA_LEN_RESET);
		write_reg(`DMA_REG_LEN, 32'd9);
		expect_reg("LEN readback", `DMA_REG_LEN, 32'd9);
		check_caps(); // zero after reset
		for (int i = 0; i < n_xfer - 1; i++)
			run_xfer(xfer_src[i], xfer_len[i]);
		// start while busy is dropped
		write_reg(`DMA_REG_LEN, xfer_len[n_xfer-1]);
		write_reg(`DMA_REG_CMD, xfer_src[n_xfer-1]);
		expect_reg("busy during transfer", `DMA_REG_STATUS, 32'd1);
		write_reg(`DMA_REG_CMD, 32'ha1);
		wait_idle();
		model_xfer(xfer_src[n_xfer-1], xfer_len[n_xfer-1]);
		repeat (20) @(posedge clk);
		#1;
		expect_reg("busy after transfer", `DMA_REG_STATUS, 32'd0);
		check_caps();
		$display("errors: %0d mismatch, %0d assertion", err_cnt, u_dut.u_chk.fail_cnt);
		if (err_cnt == 0 && u_dut.u_chk.fail_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// watchdog, scaled by the memory reads
	initial begin
		int n_rd;
		n_rd = 0;
		for (int i = 0; i < n_xfer; i++)
			n_rd += reads_for(xfer_src[i], xfer_len[i]);
		#((20 * n_rd + 2000) * clk_period);
		$display("timeout: the transfers did not finish in %0d cycles", 20 * n_rd + 2000);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/dma_chk.sv ====
////////////////////////////////////////////////////////////
// read DMA protocol checker
// bound to the top, manager and register port rules
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module dma_chk (
	input logic                   clk_i,
	input logic                   rst_ni,
	input logic                   sbr_req_i,
	input logic                   sbr_gnt_o,
	input logic [`DMA_DATA_W-1:0] sbr_addr_i,
	input logic                   sbr_we_i,
	input logic [`DMA_ID_W-1:0]   sbr_aid_i,
	input logic                   sbr_rvalid_o,
	input logic [`DMA_DATA_W-1:0] sbr_rdata_o,
	input logic [`DMA_ID_W-1:0]   sbr_rid_o,
	input logic                   mgr_req_o,
	input logic                   mgr_gnt_i,
	input logic [`DMA_DATA_W-1:0] mgr_addr_o,
	input logic                   mgr_rvalid_i
);

	int fail_cnt = 0;  // read by the testbench top
	int oust;          // reads between grant and response

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			oust <= 0;
		end else begin
			oust <= oust + int'(mgr_req_o && mgr_gnt_i) - int'(mgr_rvalid_i);
		end
	end

	////////////////////////////////////////////////////////////
	// manager port

	req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mgr_req_o && !mgr_gnt_i |=> mgr_req_o && $stable(mgr_addr_o))
	else begin
		fail_cnt++;
		$error("manager request dropped or address moved before grant");
	end

	addr_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
		mgr_req_o |-> mgr_addr_o[1:0] == 2'b00)
	else begin
		fail_cnt++;
		$error("manager address not word aligned");
	end

	oust_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
		oust <= `DMA_MAX_OUST && (mgr_rvalid_i -> oust > 0))
	else begin
		fail_cnt++;
		$error("outstanding reads out of range");
	end

	////////////////////////////////////////////////////////////
	// subordinate port

	gnt_always: assert property (@(posedge clk_i) disable iff (!rst_ni)
		sbr_req_i |-> sbr_gnt_o)
	else begin
		fail_cnt++;
		$error("subordinate request not granted");
	end

	rsp_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
		sbr_req_i && sbr_gnt_o |=> sbr_rvalid_o && sbr_rid_o == $past(sbr_aid_i))
	else begin
		fail_cnt++;
		$error("response missing or carrying the wrong id");
	end

	rsp_spurious: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(sbr_req_i && sbr_gnt_o) |=> !sbr_rvalid_o)
	else begin
		fail_cnt++;
		$error("response without a granted request");
	end

	magic_word: assert property (@(posedge clk_i) disable iff (!rst_ni)
		sbr_req_i && sbr_gnt_o && !sbr_we_i && sbr_addr_i[11:2] == `DMA_REG_MAGIC
		|=> sbr_rdata_o == `DMA_MAGIC)
	else begin
		fail_cnt++;
		$error("identification word read back wrong");
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
////////////////////////////////////////////////////////////
// testbench clock and reset
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
	parameter int period_ns  = 8,
	parameter int rst_cycles = 16
) (
	output logic clk_o,
	output logic rst_no
);

	initial begin
		clk_o = 1'b0;
		forever #(period_ns / 2) clk_o = ~clk_o;
	end

	// sync reset, released just after an edge
	initial begin
		rst_no = 1'b0;
		repeat (rst_cycles) @(posedge clk_o);
		#1;
		rst_no = 1'b1;
	end

endmodule

`default_nettype wire

// ==== source/obi_read_dma_top.sv ====
////////////////////////////////////////////////////////////
// OBI read DMA top
// register block, address generator and aligner
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module obi_read_dma_top (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	// subordinate obi
	input  logic                   sbr_req_i,
	output logic                   sbr_gnt_o,
	input  logic [`DMA_DATA_W-1:0] sbr_addr_i,
	input  logic                   sbr_we_i,
	input  logic [`DMA_DATA_W-1:0] sbr_wdata_i,
	input  logic [`DMA_ID_W-1:0]   sbr_aid_i,
	output logic                   sbr_rvalid_o,
	output logic [`DMA_DATA_W-1:0] sbr_rdata_o,
	output logic [`DMA_ID_W-1:0]   sbr_rid_o,
	// manager obi, reads only
	output logic                   mgr_req_o,
	input  logic                   mgr_gnt_i,
	output logic [`DMA_DATA_W-1:0] mgr_addr_o,
	input  logic                   mgr_rvalid_i,
	input  logic [`DMA_DATA_W-1:0] mgr_rdata_i
);

	dma_cmd_if   u_cmd_if ();
	read_beat_if u_beat_if ();

	logic                   word_valid;
	logic [`DMA_DATA_W-1:0] word_data;
	logic                   done;

	reg_decode u_reg_decode (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.sbr_req_i    (sbr_req_i),
		.sbr_gnt_o    (sbr_gnt_o),
		.sbr_addr_i   (sbr_addr_i),
		.sbr_we_i     (sbr_we_i),
		.sbr_wdata_i  (sbr_wdata_i),
		.sbr_aid_i    (sbr_aid_i),
		.sbr_rvalid_o (sbr_rvalid_o),
		.sbr_rdata_o  (sbr_rdata_o),
		.sbr_rid_o    (sbr_rid_o),
		.cmd          (u_cmd_if),
		.word_valid_i (word_valid),
		.word_data_i  (word_data),
		.done_i       (done)
	);

	read_addr_gen u_read_addr_gen (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.cmd          (u_cmd_if),
		.mgr_req_o    (mgr_req_o),
		.mgr_gnt_i    (mgr_gnt_i),
		.mgr_addr_o   (mgr_addr_o),
		.mgr_rvalid_i (mgr_rvalid_i),
		.mgr_rdata_i  (mgr_rdata_i),
		.beat         (u_beat_if)
	);

	byte_align u_byte_align (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.cmd          (u_cmd_if),
		.beat         (u_beat_if),
		.word_valid_o (word_valid),
		.word_data_o  (word_data),
		.done_o       (done)
	);

endmodule

`default_nettype wire

// ==== source/byte_align.sv ====
////////////////////////////////////////////////////////////
// byte aligner
// realigns read beats into packed little-endian words
// and zeroes the unused tail bytes
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module byte_align (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	dma_cmd_if.mon                 cmd,
	read_beat_if.dst               beat,
	// aligned stream out
	output logic                   word_valid_o,
	output logic [`DMA_DATA_W-1:0] word_data_o,
	output logic                   done_o
);

	logic            cmd_go;
	logic [2:0]      tail_span;  // offset plus length mod 4
	logic [1:0]      off_q;      // source byte offset
	logic [1:0]      rem_q;      // bytes in last word, 0 is full
	logic            flush_q;    // tail needs an extra word
	logic            shift_en;
	logic [3:0][7:0] shift_in;
	logic [6:0][7:0] win_q;      // new beat in [6:3]
	logic            pend_q;     // flush next cycle
	logic            vld_q;
	logic            last_q;
	logic [3:0][7:0] sel;
	logic [3:0]      keep;

	assign cmd_go    = cmd.valid & cmd.ready;
	assign tail_span = {1'b0, cmd.addr.f.byte_off} + {1'b0, cmd.len[1:0]};

	////////////////////////////////////////////////////////////
	// transfer setup

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			off_q   <= 2'd0;
			rem_q   <= 2'd0;
			flush_q <= 1'b0;
		end else if (cmd_go) begin
			off_q   <= cmd.addr.f.byte_off;
			rem_q   <= cmd.len[1:0];
			// unaligned and the tail ends in the last beat
			flush_q <= (cmd.addr.f.byte_off != 2'd0) && (cmd.len[1:0] != 2'd0)
				&& (tail_span <= 3'd4);
		end
	end

	////////////////////////////////////////////////////////////
	// byte window

	assign shift_en = beat.valid | pend_q;
	assign shift_in = beat.valid ? beat.rdata : '0; // flush shifts zeros

	always_ff @(posedge clk_i) begin
		if (shift_en) begin
			win_q[6:3] <= shift_in;
			win_q[2:0] <= win_q[6:4]; // keep top 3 old bytes
		end
	end

	// word per beat, first partial window dropped when unaligned
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			vld_q  <= 1'b0;
			last_q <= 1'b0;
			pend_q <= 1'b0;
		end else if (beat.valid) begin
			vld_q  <= !(beat.first && off_q != 2'd0);
			last_q <= beat.last && !flush_q;
			pend_q <= beat.last && flush_q;
		end else begin
			vld_q  <= pend_q;  // flush word
			last_q <= pend_q;
			pend_q <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// output select and tail mask

	always_comb begin
		case (off_q)
			2'd0:    sel = win_q[6:3];
			2'd1:    sel = win_q[3:0];
			2'd2:    sel = win_q[4:1];
			default: sel = win_q[5:2];
		endcase
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			keep[i] = !last_q || (rem_q == 2'd0) || (i < rem_q);
			word_data_o[8*i +: 8] = keep[i] ? sel[i] : 8'h00;
		end
	end

	assign word_valid_o = vld_q;
	assign done_o       = vld_q & last_q; // one pulse per transfer

endmodule

`default_nettype wire

// ==== source/read_addr_gen.sv ====
////////////////////////////////////////////////////////////
// read address generator
// word reads on the manager port with in-flight limit
// and first and last tags per beat
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module read_addr_gen (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	dma_cmd_if.dst                 cmd,
	// manager obi
	output logic                   mgr_req_o,
	input  logic                   mgr_gnt_i,
	output logic [`DMA_DATA_W-1:0] mgr_addr_o,
	input  logic                   mgr_rvalid_i,
	input  logic [`DMA_DATA_W-1:0] mgr_rdata_i,
	// tagged responses
	read_beat_if.src               beat
);
	import dma_pkg::*;

	localparam int unsigned oust_w = $clog2(`DMA_MAX_OUST + 1);
	localparam int unsigned ptr_w  = (`DMA_MAX_OUST > 1) ? $clog2(`DMA_MAX_OUST) : 1;

	logic                   busy_q;     // reads left to issue
	logic                   first_q;
	bus_addr_u              addr_q;     // keeps the start byte offset
	logic [`DMA_DATA_W-1:0] cnt_q;      // bytes left from addr_q
	logic [`DMA_DATA_W-1:0] span;
	logic                   last_flag;
	logic                   cmd_go;
	logic                   req_go;
	logic [oust_w-1:0]      oust_q;
	logic [1:0]             tag_mem [0:`DMA_MAX_OUST-1]; // {first, last}
	logic [ptr_w-1:0]       wr_ptr_q;
	logic [ptr_w-1:0]       rd_ptr_q;

	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(`DMA_MAX_OUST - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign cmd.ready = !busy_q && (oust_q == '0); // idle and drained
	assign cmd_go    = cmd.valid & cmd.ready;

	assign span      = cnt_q + {{(`DMA_DATA_W-2){1'b0}}, addr_q.f.byte_off};
	assign last_flag = (span <= 4); // rest fits in this word

	assign mgr_req_o  = busy_q && (oust_q < oust_w'(`DMA_MAX_OUST)); // throttle
	assign mgr_addr_o = {addr_q.f.upper, addr_q.f.word_idx, 2'b00};  // word aligned
	assign req_go     = mgr_req_o & mgr_gnt_i;

	////////////////////////////////////////////////////////////
	// address walk

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			busy_q  <= 1'b0;
			first_q <= 1'b0;
		end else if (cmd_go) begin
			busy_q  <= 1'b1;
			first_q <= 1'b1;
		end else if (req_go) begin
			first_q <= 1'b0;
			if (last_flag)
				busy_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (cmd_go) begin
			addr_q <= cmd.addr;
			cnt_q  <= cmd.len;
		end else if (req_go) begin
			addr_q.byte_addr <= addr_q.byte_addr + 4; // next word
			cnt_q            <= cnt_q - 4;
		end
	end

	////////////////////////////////////////////////////////////
	// in flight count, grant to response

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			oust_q <= '0;
		end else begin
			case ({req_go, mgr_rvalid_i})
				2'b10:   oust_q <= oust_q + 1'b1;
				2'b01:   oust_q <= oust_q - 1'b1;
				default: oust_q <= oust_q; // none or both
			endcase
		end
	end

	// tag fifo, pushed on grant and popped on response
	always_ff @(posedge clk_i) begin
		if (req_go)
			tag_mem[wr_ptr_q] <= {first_q, last_flag};
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (req_go)
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			if (mgr_rvalid_i)
				rd_ptr_q <= ptr_inc(rd_ptr_q);
		end
	end

	// responses in order so the head tag matches
	assign beat.valid               = mgr_rvalid_i;
	assign beat.rdata               = mgr_rdata_i;
	assign {beat.first, beat.last}  = tag_mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== source/reg_decode.sv ====
////////////////////////////////////////////////////////////
// register decode
// subordinate OBI access to registers and dma commands
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

module reg_decode (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	// subordinate obi
	input  logic                   sbr_req_i,
	output logic                   sbr_gnt_o,
	input  dma_pkg::bus_addr_u     sbr_addr_i,
	input  logic                   sbr_we_i,
	input  logic [`DMA_DATA_W-1:0] sbr_wdata_i,
	input  logic [`DMA_ID_W-1:0]   sbr_aid_i,
	output logic                   sbr_rvalid_o,
	output logic [`DMA_DATA_W-1:0] sbr_rdata_o,
	output logic [`DMA_ID_W-1:0]   sbr_rid_o,
	// dma start
	dma_cmd_if.src                 cmd,
	// aligned stream in
	input  logic                   word_valid_i,
	input  logic [`DMA_DATA_W-1:0] word_data_i,
	input  logic                   done_i
);
	import dma_pkg::*;

	logic                        acc;      // granted access
	logic                        wr_acc;
	reg_idx_t                    idx;
	reg_idx_t                    ridx_q;   // index of pending response
	logic [`DMA_ID_W-1:0]        rid_q;
	logic                        rvalid_q;
	logic [`DMA_DATA_W-1:0]      len_q;
	logic [2:0][`DMA_DATA_W-1:0] cap_q;    // [0] newest word
	logic                        busy_q;

	assign sbr_gnt_o = 1'b1; // never stalls
	assign acc       = sbr_req_i & sbr_gnt_o;
	assign wr_acc    = acc & sbr_we_i;
	assign idx       = sbr_addr_i.f.word_idx;

	////////////////////////////////////////////////////////////
	// response pipe

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= acc; // one cycle after grant
		end
	end

	always_ff @(posedge clk_i) begin
		if (acc) begin
			ridx_q <= idx;
			rid_q  <= sbr_aid_i;
		end
	end

	////////////////////////////////////////////////////////////
	// registers

	// length, used by the next start
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			len_q <= `DMA_LEN_RESET;
		end else if (wr_acc && idx == `DMA_REG_LEN) begin
			len_q <= sbr_wdata_i;
		end
	end

	// start pulse, dropped while a transfer runs
	assign cmd.valid = wr_acc && (idx == `DMA_REG_CMD) && !busy_q;
	assign cmd.addr  = sbr_wdata_i;
	assign cmd.len   = len_q;

	// busy from accept until the last word
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			busy_q <= 1'b0;
		end else if (cmd.valid && cmd.ready) begin
			busy_q <= 1'b1;
		end else if (done_i) begin
			busy_q <= 1'b0;
		end
	end

	// capture shift, oldest word falls off
	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			cap_q <= '0;
		end else if (word_valid_i) begin
			cap_q[2] <= cap_q[1];
			cap_q[1] <= cap_q[0];
			cap_q[0] <= word_data_i;
		end
	end

	////////////////////////////////////////////////////////////
	// read data select

	always_comb begin
		case (ridx_q)
			`DMA_REG_MAGIC:  sbr_rdata_o = `DMA_MAGIC;
			`DMA_REG_DATA0:  sbr_rdata_o = cap_q[0];
			`DMA_REG_DATA1:  sbr_rdata_o = cap_q[1];
			`DMA_REG_DATA2:  sbr_rdata_o = cap_q[2];
			`DMA_REG_LEN:    sbr_rdata_o = len_q;
			`DMA_REG_STATUS: sbr_rdata_o = {{(`DMA_DATA_W-1){1'b0}}, busy_q}; // bit 0 busy
			default:         sbr_rdata_o = `DMA_BAD_RDATA;
		endcase
	end

	assign sbr_rvalid_o = rvalid_q;
	assign sbr_rid_o    = rid_q;

endmodule

`default_nettype wire

// ==== source/dma_if.sv ====
////////////////////////////////////////////////////////////
// read DMA internal links
// command channel and tagged read beats
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "dma_settings.svh"

// dma command, one pulse per start
interface dma_cmd_if;
	import dma_pkg::*;

	logic                   valid;
	logic                   ready;
	bus_addr_u              addr;  // start byte address
	logic [`DMA_DATA_W-1:0] len;   // byte length

	modport src (output valid, output addr, output len, input ready);
	modport dst (input valid, input addr, input len, output ready);
	modport mon (input valid, input ready, input addr, input len); // align side watches
endinterface

// manager read response with stream tags
interface read_beat_if;
	logic                   valid;
	logic [`DMA_DATA_W-1:0] rdata;
	logic                   first;  // first word of the transfer
	logic                   last;   // last word of the transfer

	modport src (output valid, output rdata, output first, output last);
	modport dst (input valid, input rdata, input first, input last);
endinterface

`default_nettype wire

// ==== source/dma_pkg.sv ====
////////////////////////////////////////////////////////////
// read DMA types
// bus address views and register index
////////////////////////////////////////////////////////////
`default_nettype none

`include "dma_settings.svh"

package dma_pkg;

	// register word index
	typedef logic [9:0] reg_idx_t;

	// byte address split into word and byte fields
	typedef struct packed {
		logic [`DMA_DATA_W-13:0] upper;     // above the register window
		reg_idx_t                word_idx;  // register word index
		logic [1:0]              byte_off;  // byte within the word
	} bus_addr_s;

	// one bus address, flat or split
	typedef union packed {
		logic [`DMA_DATA_W-1:0] byte_addr;
		bus_addr_s              f;
	} bus_addr_u;

endpackage

`default_nettype wire

// ==== source/dma_settings.svh ====
////////////////////////////////////////////////////////////
// read DMA settings
// bus widths, register map, id word and read limit
////////////////////////////////////////////////////////////
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// bus widths
`define DMA_DATA_W      32
`define DMA_ID_W        4

`define DMA_MAX_OUST    2            // max manager reads in flight

`define DMA_MAGIC       32'h6943_4017
`define DMA_BAD_RDATA   32'hdead_beef // unmapped register reads
`define DMA_LEN_RESET   32'd4         // one word

// register word indices
`define DMA_REG_MAGIC   10'd0
`define DMA_REG_CMD     10'd1         // write side of index 1
`define DMA_REG_DATA0   10'd1         // read side of index 1
`define DMA_REG_DATA1   10'd2
`define DMA_REG_DATA2   10'd3
`define DMA_REG_LEN     10'd4
`define DMA_REG_STATUS  10'd5

`endif
